// File: sources.f
src/sb_cfg_pkg.sv
src/sb_types_pkg.sv
src/sb_agu.sv
src/sb_entry_queue.sv
src/sb_mem_port.sv
src/store_buffer_top.sv
sim/sb_checker.sv
sim/tb_store_buffer.sv

// File: Bender.yml
package:
  name: store_buffer

sources:
  - src/sb_cfg_pkg.sv
  - src/sb_types_pkg.sv
  - src/sb_agu.sv
  - src/sb_entry_queue.sv
  - src/sb_mem_port.sv
  - src/store_buffer_top.sv
  - target: simulation
    files:
      - sim/sb_checker.sv
      - sim/tb_store_buffer.sv

// File: sim/tb_store_buffer.sv
// store buffer testbench
// random stores through the top level, a memory model with out-of-order
// responses, and in-order scoreboards for requests and write-backs

`timescale 1ns/1ps

module tb_store_buffer;

  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;
  localparam int N_STORES   = 8 + 3 + DEPTH + 4;
  localparam int TIMEOUT    = (N_STORES * 100 + RST_CYCLES) * CLK_PERIOD;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       flush_i;
  logic       issue_valid_i;
  logic       issue_ready_o;
  issue_req_t issue_i;
  logic       cdb_valid_i;
  cdb_t       cdb_i;
  logic       cdb_valid_o;
  logic       cdb_ready_i = 1'b0;
  cdb_t       cdb_o;
  logic       mem_valid_o;
  logic       mem_ready_i = 1'b0;
  mem_req_t   mem_req_o;
  logic       mem_rsp_valid_i = 1'b0;
  mem_rsp_t   mem_rsp_i = '0;

  int               seed = 88;
  int               alloc_cnt = 0;   // stores accepted since reset or flush
  int               store_cnt = 0;
  logic             mem_en = 1'b0;   // memory model takes requests
  mem_req_t         exp_mem[$];
  cdb_t             exp_wb[$];
  logic [IDX_W-1:0] rsp_tag[$];      // accepted requests awaiting a response
  int               rsp_wait[$];

  store_buffer_top uut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("Checks failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  // low 1, 2, 4 or 8 byte lanes
  function automatic logic [BE_W-1:0] width_be(input store_width_e w);
    int nbytes;
    nbytes = 1 << int'(w);
    return BE_W'((1 << nbytes) - 1);
  endfunction

  // ------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------
  task automatic send_store(input logic wait1, input logic wait2,
                            input logic [ROB_IDX_W-1:0] rob1,
                            input logic [ROB_IDX_W-1:0] rob2,
                            output logic [XLEN-1:0] base, output logic [XLEN-1:0] data);
    issue_req_t req;
    mem_req_t   exp_req;
    cdb_t       exp_out;
    base             = {$random(seed), $random(seed)};
    data             = {$random(seed), $random(seed)};
    req.width        = store_width_e'(2'($random(seed)));
    req.rs1.ready    = !wait1;
    req.rs1.rob_idx  = rob1;
    req.rs1.value    = wait1 ? ~base : base;  // stale value while waiting
    req.rs2.ready    = !wait2;
    req.rs2.rob_idx  = rob2;
    req.rs2.value    = wait2 ? ~data : data;
    req.imm          = XLEN'($random(seed));  // sign extended, negative offsets too
    req.dest_rob_idx = ROB_IDX_W'(store_cnt);
    store_cnt++;
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_i       <= req;
    @(negedge clk_i);
    while (!issue_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    exp_req.addr  = base + req.imm;
    exp_req.wdata = data;
    exp_req.be    = width_be(req.width);
    exp_req.tag   = IDX_W'(alloc_cnt);
    exp_mem.push_back(exp_req);
    exp_out.rob_idx = req.dest_rob_idx;
    exp_out.value   = exp_req.addr;
    exp_wb.push_back(exp_out);
    alloc_cnt++;
  endtask

  task automatic broadcast(input logic [ROB_IDX_W-1:0] rob, input logic [XLEN-1:0] value);
    @(posedge clk_i);
    cdb_valid_i <= 1'b1;
    cdb_i       <= '{rob_idx: rob, value: value};
    @(posedge clk_i);
    cdb_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    do @(posedge clk_i); while (exp_wb.size() != 0);
  endtask

  task automatic flush_buffer();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    exp_mem.delete();
    exp_wb.delete();
    alloc_cnt = 0;
    @(negedge clk_i);
    assert (!cdb_valid_o && !mem_valid_o && issue_ready_o) else begin
      $display("mismatch at %0t: buffer not idle the cycle after flush", $time);
      stop_on_error();
    end
  endtask

  // ------------------------------------------------------------
  // memory model and bus consumer
  // ------------------------------------------------------------
  always @(posedge clk_i) begin : responder
    int pick;
    pick = -1;
    foreach (rsp_wait[i]) begin
      if (rsp_wait[i] == 0 && pick < 0) begin
        pick = i;
      end else if (rsp_wait[i] > 0) begin
        rsp_wait[i] = rsp_wait[i] - 1;
      end
    end
    mem_rsp_valid_i <= (pick >= 0);
    if (pick >= 0) begin
      mem_rsp_i.tag <= rsp_tag[pick];  // any order, oldest ready first
      rsp_tag.delete(pick);
      rsp_wait.delete(pick);
    end
    mem_ready_i <= mem_en && ({$random(seed)} % 2 == 0);
    cdb_ready_i <= ({$random(seed)} % 4 != 0);
  end

  always @(negedge clk_i) begin : req_check
    mem_req_t exp_req;
    if (rst_ni && mem_valid_o && mem_ready_i) begin
      assert (exp_mem.size() != 0) else begin
        $display("memory request at %0t with no store waiting for one", $time);
        stop_on_error();
      end
      exp_req = exp_mem.pop_front();
      assert (mem_req_o == exp_req) else begin
        $display("mismatch at %0t: request %h, expected %h", $time, mem_req_o, exp_req);
        stop_on_error();
      end
      rsp_tag.push_back(mem_req_o.tag);
      rsp_wait.push_back({$random(seed)} % 6);
    end
  end

  always @(negedge clk_i) begin : wb_check
    cdb_t exp_out;
    if (rst_ni && cdb_valid_o && cdb_ready_i) begin
      assert (exp_wb.size() != 0) else begin
        $display("write-back at %0t with no store outstanding", $time);
        stop_on_error();
      end
      exp_out = exp_wb.pop_front();
      assert (cdb_o == exp_out) else begin
        $display("mismatch at %0t: write-back %h, expected %h", $time, cdb_o, exp_out);
        stop_on_error();
      end
    end
  end

  always @(negedge clk_i) begin
    assert (uut.u_checker.err_cnt == 0) else begin
      $display("a protocol assertion on the store buffer ports failed");
      stop_on_error();
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] late [4];  // operand values sent on the bus later
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    cdb_valid_i   = 1'b0;
    cdb_i         = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (issue_ready_o && !cdb_valid_o && !mem_valid_o) else begin
      $display("mismatch at %0t: outputs not idle after reset", $time);
      stop_on_error();
    end
    mem_en <= 1'b1;

    repeat (8) send_store(1'b0, 1'b0, '0, '0, base, data);

    // pending operands, broadcast out of order
    send_store(1'b1, 1'b0, 4'd1, 4'd0, late[0], data);
    send_store(1'b0, 1'b1, 4'd0, 4'd2, base, late[1]);
    send_store(1'b1, 1'b1, 4'd3, 4'd4, late[2], late[3]);
    broadcast(4'd2, late[1]);
    broadcast(4'd3, late[2]);
    broadcast(4'd1, late[0]);
    broadcast(4'd4, late[3]);
    wait_drain();

    // memory stalled until every entry is taken
    mem_en <= 1'b0;
    repeat (DEPTH) send_store(1'b0, 1'b0, '0, '0, base, data);
    @(negedge clk_i);
    assert (!issue_ready_o) else begin
      $display("mismatch at %0t: issue_ready_o stayed high with every entry in use", $time);
      stop_on_error();
    end
    flush_buffer();

    mem_en <= 1'b1;
    repeat (4) send_store(1'b0, 1'b0, '0, '0, base, data);
    wait_drain();

    if (uut.u_checker.err_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_on_error();
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("timeout: the store buffer stopped making progress");
    stop_on_error();
  end

endmodule

// File: sim/sb_checker.sv
// store buffer protocol checker
// handshake stability plus idle outputs after reset and after flush

`timescale 1ns/1ps

module sb_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   flush_i,
  input logic                   issue_ready_i,
  input logic                   wb_valid_i,
  input logic                   wb_ready_i,
  input sb_types_pkg::cdb_t     wb_i,
  input logic                   req_valid_i,
  input logic                   req_ready_i,
  input sb_types_pkg::mem_req_t req_i
);

  int unsigned err_cnt = 0;  // failed assertions so far

  // ------------------------------------------------------------
  // handshakes
  // ------------------------------------------------------------
  // a flush at the starting edge empties the buffer, so no hold follows
  wb_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_valid_i && !wb_ready_i && !flush_i |=> wb_valid_i && $stable(wb_i))
    else begin
      err_cnt++;
      $error("write-back dropped or changed while cdb_ready_i was low");
    end

  req_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_valid_i && !req_ready_i && !flush_i |=> req_valid_i && $stable(req_i))
    else begin
      err_cnt++;
      $error("memory request dropped or changed while mem_ready_i was low");
    end

  // first cycle out of reset
  reset_idle_a : assert property (@(posedge clk_i)
      $rose(rst_ni) |-> issue_ready_i && !wb_valid_i && !req_valid_i)
    else begin
      err_cnt++;
      $error("outputs active right after reset");
    end

  flush_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      flush_i |=> !wb_valid_i && !req_valid_i && issue_ready_i)
    else begin
      err_cnt++;
      $error("outputs active the cycle after flush");
    end

endmodule

bind store_buffer_top sb_checker u_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .flush_i       (flush_i),
  .issue_ready_i (issue_ready_o),
  .wb_valid_i    (cdb_valid_o),
  .wb_ready_i    (cdb_ready_i),
  .wb_i          (cdb_o),
  .req_valid_i   (mem_valid_o),
  .req_ready_i   (mem_ready_i),
  .req_i         (mem_req_o)
);

// File: src/store_buffer_top.sv
// bare-metal store buffer
// address unit feeding the entry queue, drained in order by the memory port

`timescale 1ns/1ps

module store_buffer_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  sb_types_pkg::issue_req_t issue_i,
  input  logic                     cdb_valid_i,
  input  sb_types_pkg::cdb_t       cdb_i,
  output logic                     cdb_valid_o,
  input  logic                     cdb_ready_i,
  output sb_types_pkg::cdb_t       cdb_o,
  output logic                     mem_valid_o,
  input  logic                     mem_ready_i,
  output sb_types_pkg::mem_req_t   mem_req_o,
  input  logic                     mem_rsp_valid_i,
  input  sb_types_pkg::mem_rsp_t   mem_rsp_i
);

  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  // ------------------------------------------------------------
  // internal wires
  // ------------------------------------------------------------
  logic             agu_req_valid;
  logic             agu_req_ready;
  agu_req_t         agu_req;
  logic             agu_ans_valid;
  agu_ans_t         agu_ans;
  logic [IDX_W-1:0] mem_idx;
  entry_view_t      mem_view;
  logic             mem_issued;
  logic             mem_done;
  logic [IDX_W-1:0] mem_done_tag;

  sb_agu u_agu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_valid_i (agu_req_valid),
    .req_ready_o (agu_req_ready),
    .req_i       (agu_req),
    .ans_valid_o (agu_ans_valid),
    .ans_o       (agu_ans)
  );

  sb_entry_queue u_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .issue_valid_i   (issue_valid_i),
    .issue_ready_o   (issue_ready_o),
    .issue_i         (issue_i),
    .cdb_valid_i     (cdb_valid_i),
    .cdb_i           (cdb_i),
    .cdb_valid_o     (cdb_valid_o),
    .cdb_ready_i     (cdb_ready_i),
    .cdb_o           (cdb_o),
    .agu_req_valid_o (agu_req_valid),
    .agu_req_ready_i (agu_req_ready),
    .agu_req_o       (agu_req),
    .agu_ans_valid_i (agu_ans_valid),
    .agu_ans_i       (agu_ans),
    .mem_idx_i       (mem_idx),
    .mem_view_o      (mem_view),
    .mem_issued_i    (mem_issued),
    .mem_done_i      (mem_done),
    .mem_done_tag_i  (mem_done_tag)
  );

  sb_mem_port u_mem_port (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .mem_idx_o       (mem_idx),
    .mem_view_i      (mem_view),
    .mem_issued_o    (mem_issued),
    .mem_done_o      (mem_done),
    .mem_done_tag_o  (mem_done_tag),
    .mem_valid_o     (mem_valid_o),
    .mem_ready_i     (mem_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i)
  );

endmodule

// File: src/sb_mem_port.sv
// store buffer memory port
// issues tagged write requests in order and turns responses into
// completions for the tagged entry

`timescale 1ns/1ps

module sb_mem_port (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  output logic [sb_cfg_pkg::IDX_W-1:0]  mem_idx_o,
  input  sb_types_pkg::entry_view_t     mem_view_i,
  output logic                          mem_issued_o,
  output logic                          mem_done_o,
  output logic [sb_cfg_pkg::IDX_W-1:0]  mem_done_tag_o,
  output logic                          mem_valid_o,
  input  logic                          mem_ready_i,
  output sb_types_pkg::mem_req_t        mem_req_o,
  input  logic                          mem_rsp_valid_i,
  input  sb_types_pkg::mem_rsp_t        mem_rsp_i
);

  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  logic [IDX_W-1:0] idx_q;  // next store to send
  logic [BE_W-1:0]  be;

  // in-order pointer, moves on accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (flush_i) begin
      idx_q <= '0;
    end else if (mem_issued_o) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // low bytes only, data is not aligned to the address
  always_comb begin
    unique case (mem_view_i.width)
      SW_BYTE:   be = BE_W'(8'h01);
      SW_HALF:   be = BE_W'(8'h03);
      SW_WORD:   be = BE_W'(8'h0f);
      SW_DOUBLE: be = '1;
    endcase
  end

  assign mem_idx_o       = idx_q;
  assign mem_valid_o     = mem_view_i.ready;
  assign mem_issued_o    = mem_valid_o & mem_ready_i;
  assign mem_req_o.addr  = mem_view_i.addr;
  assign mem_req_o.wdata = mem_view_i.data;
  assign mem_req_o.be    = be;
  assign mem_req_o.tag   = idx_q;

  // responses may come back in any order
  assign mem_done_o     = mem_rsp_valid_i;
  assign mem_done_tag_o = mem_rsp_i.tag;

endmodule

// File: src/sb_entry_queue.sv
// store buffer entry queue
// in-order store entries with one state machine each; snoops operands
// from the bus, feeds the address unit and writes back from the head

`timescale 1ns/1ps

module sb_entry_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          issue_valid_i,
  output logic                          issue_ready_o,
  input  sb_types_pkg::issue_req_t      issue_i,
  input  logic                          cdb_valid_i,
  input  sb_types_pkg::cdb_t            cdb_i,
  output logic                          cdb_valid_o,
  input  logic                          cdb_ready_i,
  output sb_types_pkg::cdb_t            cdb_o,
  output logic                          agu_req_valid_o,
  input  logic                          agu_req_ready_i,
  output sb_types_pkg::agu_req_t        agu_req_o,
  input  logic                          agu_ans_valid_i,
  input  sb_types_pkg::agu_ans_t        agu_ans_i,
  input  logic [sb_cfg_pkg::IDX_W-1:0]  mem_idx_i,
  output sb_types_pkg::entry_view_t     mem_view_o,
  input  logic                          mem_issued_i,
  input  logic                          mem_done_i,
  input  logic [sb_cfg_pkg::IDX_W-1:0]  mem_done_tag_i
);

  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  typedef struct packed {
    store_width_e         width;
    logic [ROB_IDX_W-1:0] rs1_rob_idx;
    logic [ROB_IDX_W-1:0] rs2_rob_idx;
    logic [XLEN-1:0]      base;  // rs1 value
    logic [XLEN-1:0]      data;  // rs2 value
    logic [XLEN-1:0]      addr;  // holds imm until the address comes back
    logic [ROB_IDX_W-1:0] dest_rob_idx;
  } entry_t;

  entry_t           entry_q [DEPTH];
  entry_state_e     state_q [DEPTH];
  entry_state_e     state_d [DEPTH];
  logic [IDX_W-1:0] head_q;      // oldest store, writes back
  logic [IDX_W-1:0] tail_q;      // next free entry
  logic [IDX_W-1:0] addr_idx_q;  // next store to the agu

  logic             push;
  logic             pop;
  logic             agu_fire;
  logic             rs1_ok;  // operand available when pushed
  logic             rs2_ok;
  logic [DEPTH-1:0] push_sel;
  logic [DEPTH-1:0] cap_rs1;
  logic [DEPTH-1:0] cap_rs2;
  logic [DEPTH-1:0] save_addr;

  assign push     = issue_valid_i & issue_ready_o;
  assign pop      = cdb_valid_o & cdb_ready_i;
  assign agu_fire = agu_req_valid_o & agu_req_ready_i;

  // a broadcast in the issue cycle also counts
  assign rs1_ok = issue_i.rs1.ready | (cdb_valid_i & (cdb_i.rob_idx == issue_i.rs1.rob_idx));
  assign rs2_ok = issue_i.rs2.ready | (cdb_valid_i & (cdb_i.rob_idx == issue_i.rs2.rob_idx));

  // ------------------------------------------------------------
  // per-entry state progression
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      push_sel[i]  = push && (tail_q == IDX_W'(i));
      cap_rs1[i]   = cdb_valid_i && (cdb_i.rob_idx == entry_q[i].rs1_rob_idx) &&
                     (state_q[i] == S_RS12_PENDING || state_q[i] == S_RS1_PENDING);
      cap_rs2[i]   = cdb_valid_i && (cdb_i.rob_idx == entry_q[i].rs2_rob_idx) &&
                     (state_q[i] == S_RS12_PENDING || state_q[i] == S_RS2_PENDING);
      save_addr[i] = agu_ans_valid_i && (agu_ans_i.tag == IDX_W'(i)) &&
                     (state_q[i] == S_ADDR_WAIT);

      state_d[i] = state_q[i];
      unique case (state_q[i])
        S_EMPTY: begin
          if (push_sel[i]) begin
            unique case ({rs1_ok, rs2_ok})
              2'b11:   state_d[i] = S_ADDR_REQ;
              2'b01:   state_d[i] = S_RS1_PENDING;
              2'b10:   state_d[i] = S_RS2_PENDING;
              default: state_d[i] = S_RS12_PENDING;
            endcase
          end
        end
        S_RS12_PENDING: begin
          unique case ({cap_rs1[i], cap_rs2[i]})
            2'b11:   state_d[i] = S_ADDR_REQ;
            2'b10:   state_d[i] = S_RS2_PENDING;
            2'b01:   state_d[i] = S_RS1_PENDING;
            default: state_d[i] = S_RS12_PENDING;
          endcase
        end
        S_RS1_PENDING: if (cap_rs1[i]) state_d[i] = S_ADDR_REQ;
        S_RS2_PENDING: if (cap_rs2[i]) state_d[i] = S_ADDR_REQ;
        S_ADDR_REQ:    if (agu_fire && addr_idx_q == IDX_W'(i)) state_d[i] = S_ADDR_WAIT;
        S_ADDR_WAIT:   if (save_addr[i]) state_d[i] = S_MEM_REQ;
        S_MEM_REQ:     if (mem_issued_i && mem_idx_i == IDX_W'(i)) state_d[i] = S_MEM_WAIT;
        S_MEM_WAIT:    if (mem_done_i && mem_done_tag_i == IDX_W'(i)) state_d[i] = S_COMPLETED;
        S_COMPLETED:   if (pop && head_q == IDX_W'(i)) state_d[i] = S_EMPTY;
        default:       state_d[i] = S_EMPTY;
      endcase
    end
  end

  // states and pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= '{default: S_EMPTY};
      head_q     <= '0;
      tail_q     <= '0;
      addr_idx_q <= '0;
    end else if (flush_i) begin
      state_q    <= '{default: S_EMPTY};
      head_q     <= '0;
      tail_q     <= '0;
      addr_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (pop) head_q <= head_q + 1'b1;
      if (push) tail_q <= tail_q + 1'b1;
      if (agu_fire) addr_idx_q <= addr_idx_q + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // entry payload
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (push_sel[i]) begin
        entry_q[i].width        <= issue_i.width;
        entry_q[i].rs1_rob_idx  <= issue_i.rs1.rob_idx;
        entry_q[i].rs2_rob_idx  <= issue_i.rs2.rob_idx;
        entry_q[i].base         <= issue_i.rs1.ready ? issue_i.rs1.value : cdb_i.value;
        entry_q[i].data         <= issue_i.rs2.ready ? issue_i.rs2.value : cdb_i.value;
        entry_q[i].addr         <= issue_i.imm;
        entry_q[i].dest_rob_idx <= issue_i.dest_rob_idx;
      end
      if (cap_rs1[i]) entry_q[i].base <= cdb_i.value;
      if (cap_rs2[i]) entry_q[i].data <= cdb_i.value;
      if (save_addr[i]) entry_q[i].addr <= agu_ans_i.addr;
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign issue_ready_o = (state_q[tail_q] == S_EMPTY);

  assign cdb_valid_o   = (state_q[head_q] == S_COMPLETED);
  assign cdb_o.rob_idx = entry_q[head_q].dest_rob_idx;
  assign cdb_o.value   = entry_q[head_q].addr;  // store address on write-back

  assign agu_req_valid_o  = (state_q[addr_idx_q] == S_ADDR_REQ);
  assign agu_req_o.tag    = addr_idx_q;
  assign agu_req_o.base   = entry_q[addr_idx_q].base;
  assign agu_req_o.offset = entry_q[addr_idx_q].addr;

  assign mem_view_o.ready = (state_q[mem_idx_i] == S_MEM_REQ);
  assign mem_view_o.addr  = entry_q[mem_idx_i].addr;
  assign mem_view_o.data  = entry_q[mem_idx_i].data;
  assign mem_view_o.width = entry_q[mem_idx_i].width;

endmodule

// File: src/sb_agu.sv
// store address generation unit
// pipelined base plus offset adder, operands registered first and the
// sum in the following stage; never stalls

`timescale 1ns/1ps

module sb_agu (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  sb_types_pkg::agu_req_t req_i,
  output logic                   ans_valid_o,
  output sb_types_pkg::agu_ans_t ans_o
);

  import sb_cfg_pkg::*;

  logic                             req_fire;
  logic [AGU_STAGES-1:0]            vld_q;   // one valid bit per stage
  logic [AGU_STAGES-1:0][IDX_W-1:0] tag_q;   // entry tag per stage
  logic [XLEN-1:0]                  base_q;  // first stage operands
  logic [XLEN-1:0]                  offs_q;
  logic [AGU_STAGES-1:1][XLEN-1:0]  addr_q;  // sum and later copies

  assign req_ready_o = 1'b1;  // later stages always advance
  assign req_fire    = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (flush_i) begin
      vld_q <= '0;  // drop everything in flight
    end else begin
      vld_q <= {vld_q[AGU_STAGES-2:0], req_fire};
    end
  end

  // ------------------------------------------------------------
  // payload
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    tag_q <= {tag_q[AGU_STAGES-2:0], req_i.tag};
    if (req_fire) begin
      base_q <= req_i.base;
      offs_q <= req_i.offset;
    end
    for (int k = AGU_STAGES - 1; k > 1; k--) begin
      addr_q[k] <= addr_q[k-1];
    end
    addr_q[1] <= base_q + offs_q;
  end

  assign ans_valid_o = vld_q[AGU_STAGES-1];
  assign ans_o.tag   = tag_q[AGU_STAGES-1];
  assign ans_o.addr  = addr_q[AGU_STAGES-1];

endmodule

// File: src/sb_types_pkg.sv
// store buffer traffic types
// issue, common data bus, address generation and memory transfers,
// plus the per-entry state encoding

package sb_types_pkg;

  import sb_cfg_pkg::*;

  typedef enum logic [1:0] {
    SW_BYTE   = 2'd0,
    SW_HALF   = 2'd1,
    SW_WORD   = 2'd2,
    SW_DOUBLE = 2'd3
  } store_width_e;

  // source operand as seen at issue
  typedef struct packed {
    logic                 ready;    // value valid, else wait on rob_idx
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [XLEN-1:0]      value;
  } operand_t;

  typedef struct packed {
    store_width_e         width;
    operand_t             rs1;           // base
    operand_t             rs2;           // data to store
    logic [XLEN-1:0]      imm;           // offset
    logic [ROB_IDX_W-1:0] dest_rob_idx;
  } issue_req_t;

  // common data bus, both directions
  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [XLEN-1:0]      value;
  } cdb_t;

  typedef struct packed {
    logic [IDX_W-1:0] tag;
    logic [XLEN-1:0]  base;
    logic [XLEN-1:0]  offset;
  } agu_req_t;

  typedef struct packed {
    logic [IDX_W-1:0] tag;
    logic [XLEN-1:0]  addr;
  } agu_ans_t;

  typedef struct packed {
    logic [XLEN-1:0]  addr;
    logic [XLEN-1:0]  wdata;
    logic [BE_W-1:0]  be;
    logic [IDX_W-1:0] tag;
  } mem_req_t;

  typedef struct packed {
    logic [IDX_W-1:0] tag;
  } mem_rsp_t;

  typedef enum logic [3:0] {
    S_EMPTY,
    S_RS12_PENDING,
    S_RS1_PENDING,
    S_RS2_PENDING,
    S_ADDR_REQ,
    S_ADDR_WAIT,
    S_MEM_REQ,
    S_MEM_WAIT,
    S_COMPLETED
  } entry_state_e;

  // entry as presented to the memory port
  typedef struct packed {
    logic            ready;  // entry waits for its memory request
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    store_width_e    width;
  } entry_view_t;

endpackage

// File: src/sb_cfg_pkg.sv
// store buffer configuration
// sizes and widths shared by all blocks of the store buffer

package sb_cfg_pkg;

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  localparam int unsigned XLEN      = 64;        // data and address width
  localparam int unsigned BE_W      = XLEN / 8;  // one enable per byte
  localparam int unsigned ROB_IDX_W = 4;         // reorder buffer index

  // ------------------------------------------------------------
  // buffer organisation
  // ------------------------------------------------------------
  localparam int unsigned DEPTH      = 4;              // store entries
  localparam int unsigned IDX_W      = $clog2(DEPTH);  // entry index
  localparam int unsigned AGU_STAGES = 2;              // address pipeline depth

endpackage
